/* axis_pkg.sv */
package axis_pkg;

   // ---------------------------------------------------------
   // stream field widths
   // ---------------------------------------------------------

   localparam int DATA_WIDTH = 64;               // payload bits per beat
   localparam int KEEP_WIDTH = DATA_WIDTH / 8;   // one enable per byte
   localparam int USER_WIDTH = 10;               // vendor sideband

   // field types
   typedef logic [DATA_WIDTH-1:0] axis_data_t;
   typedef logic [KEEP_WIDTH-1:0] axis_keep_t;
   typedef logic [USER_WIDTH-1:0] axis_user_t;

   // ---------------------------------------------------------
   // register slice styles
   // ---------------------------------------------------------

   // full throughput, registered tready, two beats of storage
   localparam int MODE_SKID   = 0;

   // full throughput, tready comes through from downstream
   localparam int MODE_SIMPLE = 1;

   // half throughput, every output is a flop
   localparam int MODE_BUBBLE = 2;

   // no registers at all
   localparam int MODE_BYPASS = 3;

endpackage

/* axis_if.sv */
interface axis_if import axis_pkg::*; (
   input logic clk,
   input logic reset
);

   logic       tvalid;   // beat present
   logic       tready;   // sink can take it
   axis_data_t tdata;
   axis_keep_t tkeep;    // byte enables
   logic       tlast;    // end of packet
   axis_user_t tuser;    // vendor sideband

   // upstream side of a link, owns the beat
   modport source (
      input  clk,
      input  reset,
      output tvalid,
      output tdata,
      output tkeep,
      output tlast,
      output tuser,
      input  tready
   );

   // downstream side, owns the ready
   modport sink (
      input  clk,
      input  reset,
      input  tvalid,
      input  tdata,
      input  tkeep,
      input  tlast,
      input  tuser,
      output tready
   );

endinterface

/* axis_register.sv */
module axis_register import axis_pkg::*; #(
   parameter int MODE           = MODE_SKID,
   parameter bit TREADY_RST_VAL = 1'b0
) (
   input  logic   clk,
   input  logic   reset,
   axis_if.sink   s,
   axis_if.source m
);

   // all fields of one beat moved as a single word
   localparam int BEAT_WIDTH = DATA_WIDTH + KEEP_WIDTH + USER_WIDTH + 1;

   logic [BEAT_WIDTH-1:0] s_beat;
   logic [BEAT_WIDTH-1:0] m_beat;
   logic                  m_valid;
   logic                  s_ready;

   assign s_beat = {s.tdata, s.tkeep, s.tuser, s.tlast};

   // outputs, common to every style
   assign {m.tdata, m.tkeep, m.tuser, m.tlast} = m_beat;
   assign m.tvalid = m_valid;
   assign s.tready = s_ready;

   if (MODE == MODE_SKID) begin : g_skid
      // ---------------------------------------------------------
      // skid buffer
      // ---------------------------------------------------------
      logic                  skid_valid;
      logic [BEAT_WIDTH-1:0] skid_beat;
      logic                  skid_valid_next;
      logic                  accept;
      logic                  out_free;

      assign accept   = s.tvalid && s_ready;
      assign out_free = !m_valid || m.tready;   // output reg empty or draining

      // skid fills only when the output stalls
      always_comb begin
         skid_valid_next = skid_valid;
         if (out_free)
            skid_valid_next = 1'b0;   // skid moves into output reg
         else if (accept)
            skid_valid_next = 1'b1;
      end

      always_ff @(posedge clk) begin
         if (reset) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= TREADY_RST_VAL;
         end else begin
            if (out_free)
               m_valid <= skid_valid || accept;
            skid_valid <= skid_valid_next;
            s_ready    <= !skid_valid_next;   // ready means skid empty
         end
      end

      always_ff @(posedge clk) begin
         if (out_free) begin
            if (skid_valid)
               m_beat <= skid_beat;   // oldest beat first
            else if (accept)
               m_beat <= s_beat;
         end else if (accept) begin
            skid_beat <= s_beat;      // park it, tready drops next cycle
         end
      end

   end else if (MODE == MODE_SIMPLE) begin : g_simple
      // ---------------------------------------------------------
      // simple buffer
      // ---------------------------------------------------------
      logic rdy_en;   // holds tready at its reset value while in reset

      always_ff @(posedge clk) begin
         if (reset)
            rdy_en <= TREADY_RST_VAL;
         else
            rdy_en <= 1'b1;
      end

      // same cycle as downstream
      assign s_ready = rdy_en && (m.tready || !m_valid);

      always_ff @(posedge clk) begin
         if (reset)
            m_valid <= 1'b0;
         else if (s_ready)
            m_valid <= s.tvalid;
      end

      always_ff @(posedge clk) begin
         if (s.tvalid && s_ready)
            m_beat <= s_beat;
      end

   end else if (MODE == MODE_BUBBLE) begin : g_bubble
      // ---------------------------------------------------------
      // bubble buffer
      // ---------------------------------------------------------
      logic accept;
      logic m_valid_next;

      assign accept = s.tvalid && s_ready;

      always_comb begin
         m_valid_next = m_valid;
         if (accept)
            m_valid_next = 1'b1;
         else if (m.tready)
            m_valid_next = 1'b0;
      end

      always_ff @(posedge clk) begin
         if (reset) begin
            m_valid <= 1'b0;
            s_ready <= TREADY_RST_VAL;
         end else begin
            m_valid <= m_valid_next;
            s_ready <= !m_valid_next;   // take a beat only into an empty reg
         end
      end

      always_ff @(posedge clk) begin
         if (accept)
            m_beat <= s_beat;
      end

   end else begin : g_bypass
      // any other code ends up here
      assign m_valid = s.tvalid;
      assign s_ready = m.tready;
      assign m_beat  = s_beat;
   end

endmodule

/* axis_pipeline.sv */
module axis_pipeline import axis_pkg::*; #(
   parameter int MODE           = MODE_SKID,
   parameter bit TREADY_RST_VAL = 1'b0,
   parameter int PL_DEPTH       = 1
) (
   input logic    clk,
   input logic    reset,
   axis_if.sink   axis_s,
   axis_if.source axis_m
);

   // links between slices, element n feeds slice n
   axis_if axis_pl [PL_DEPTH:0] (
      .clk   (clk),
      .reset (reset)
   );

   // ---------------------------------------------------------
   // chain input
   // ---------------------------------------------------------

   assign axis_pl[0].tvalid = axis_s.tvalid;
   assign axis_pl[0].tdata  = axis_s.tdata;
   assign axis_pl[0].tkeep  = axis_s.tkeep;
   assign axis_pl[0].tlast  = axis_s.tlast;
   assign axis_pl[0].tuser  = axis_s.tuser;
   assign axis_s.tready     = axis_pl[0].tready;

   // ---------------------------------------------------------
   // chain output
   // ---------------------------------------------------------

   assign axis_m.tvalid = axis_pl[PL_DEPTH].tvalid;
   assign axis_m.tdata  = axis_pl[PL_DEPTH].tdata;
   assign axis_m.tkeep  = axis_pl[PL_DEPTH].tkeep;
   assign axis_m.tlast  = axis_pl[PL_DEPTH].tlast;
   assign axis_m.tuser  = axis_pl[PL_DEPTH].tuser;

   assign axis_pl[PL_DEPTH].tready = axis_m.tready;   // downstream ready

   // with depth zero both ends meet on element 0
   for (genvar n = 0; n < PL_DEPTH; n++) begin : g_stage
      axis_register #(
         .MODE           (MODE),
         .TREADY_RST_VAL (TREADY_RST_VAL)
      ) axis_reg_i (
         .clk   (clk),
         .reset (reset),
         .s     (axis_pl[n]),
         .m     (axis_pl[n+1])
      );
   end

endmodule

/* axis_pipeline_top.sv */
module axis_pipeline_top import axis_pkg::*; #(
   parameter int MODE           = MODE_SKID,
   parameter bit TREADY_RST_VAL = 1'b0,
   parameter int PL_DEPTH       = 1
) (
   input  logic       clk,
   input  logic       reset,

   // upstream stream
   input  logic       s_tvalid,
   output logic       s_tready,
   input  axis_data_t s_tdata,
   input  axis_keep_t s_tkeep,
   input  logic       s_tlast,
   input  axis_user_t s_tuser,

   // downstream stream
   output logic       m_tvalid,
   input  logic       m_tready,
   output axis_data_t m_tdata,
   output axis_keep_t m_tkeep,
   output logic       m_tlast,
   output axis_user_t m_tuser
);

   axis_if axis_in (
      .clk   (clk),
      .reset (reset)
   );

   axis_if axis_out (
      .clk   (clk),
      .reset (reset)
   );

   // ---------------------------------------------------------
   // ports onto the interfaces
   // ---------------------------------------------------------

   assign axis_in.tvalid = s_tvalid;
   assign axis_in.tdata  = s_tdata;
   assign axis_in.tkeep  = s_tkeep;
   assign axis_in.tlast  = s_tlast;
   assign axis_in.tuser  = s_tuser;
   assign s_tready       = axis_in.tready;

   assign m_tvalid        = axis_out.tvalid;
   assign m_tdata         = axis_out.tdata;
   assign m_tkeep         = axis_out.tkeep;
   assign m_tlast         = axis_out.tlast;
   assign m_tuser         = axis_out.tuser;
   assign axis_out.tready = m_tready;

   // ---------------------------------------------------------
   // slice chain
   // ---------------------------------------------------------

   axis_pipeline #(
      .MODE           (MODE),
      .TREADY_RST_VAL (TREADY_RST_VAL),
      .PL_DEPTH       (PL_DEPTH)
   ) axis_pipeline_i (
      .clk    (clk),
      .reset  (reset),
      .axis_s (axis_in),
      .axis_m (axis_out)
   );

endmodule

/* axis_pipeline_checker.sv */
module axis_pipeline_checker import axis_pkg::*; #(
   parameter int MODE           = MODE_SKID,
   parameter bit TREADY_RST_VAL = 1'b0,
   parameter int PL_DEPTH       = 1
) (
   input logic       clk,
   input logic       reset,
   input logic       s_tvalid,
   input logic       s_tready,
   input axis_data_t s_tdata,
   input logic       m_tvalid,
   input logic       m_tready,
   input axis_data_t m_tdata
);
   timeunit 1ns;
   timeprecision 1ps;

   // no registers between the two ends
   localparam bit PASSTHRU = (MODE == MODE_BYPASS) || (PL_DEPTH == 0);

   int fail_count = 0;   // assertion failures so far

   // ---------------------------------------------------------
   // stalled beats stay put
   // ---------------------------------------------------------

   a_m_hold: assert property (
      @(posedge clk) disable iff (reset)
      m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata)
   ) else begin
      fail_count++;
      $error("output beat changed or vanished while stalled");
   end

   // the stimulus has to obey the same rule
   a_s_hold: assert property (
      @(posedge clk) disable iff (reset)
      s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata)
   ) else begin
      fail_count++;
      $error("input beat changed or vanished while stalled");
   end

   // ---------------------------------------------------------
   // reset state, also the first cycle after it
   // ---------------------------------------------------------

   a_reset_valid: assert property (
      @(posedge clk) !PASSTHRU && reset |=> !m_tvalid
   ) else begin
      fail_count++;
      $error("output valid high during reset");
   end

   a_reset_ready: assert property (
      @(posedge clk) !PASSTHRU && reset |=> s_tready == TREADY_RST_VAL
   ) else begin
      fail_count++;
      $error("input ready differs from its reset value");
   end

endmodule

bind axis_pipeline_top axis_pipeline_checker #(
   .MODE           (MODE),
   .TREADY_RST_VAL (TREADY_RST_VAL),
   .PL_DEPTH       (PL_DEPTH)
) axis_pipeline_checker_i (
   .clk      (clk),
   .reset    (reset),
   .s_tvalid (s_tvalid),
   .s_tready (s_tready),
   .s_tdata  (s_tdata),
   .m_tvalid (m_tvalid),
   .m_tready (m_tready),
   .m_tdata  (m_tdata)
);

/* axis_pipeline_tb.sv */
module axis_pipeline_tb import axis_pkg::*; #(
   parameter int MODE           = MODE_SKID,
   parameter bit TREADY_RST_VAL = 1'b0,
   parameter int PL_DEPTH       = 3
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_BEATS       = 2000;
   localparam int RESET_CYCLES    = 8;
   localparam int STALL_FACTOR    = 2;               // random valid and ready slow the run
   localparam int DIRECTED_CYCLES = 300 + 8 * PL_DEPTH;
   localparam int WATCHDOG_CYCLES = NUM_BEATS * 4 * STALL_FACTOR + PL_DEPTH
                                    + RESET_CYCLES + DIRECTED_CYCLES;
   localparam bit PASSTHRU        = (MODE == MODE_BYPASS) || (PL_DEPTH == 0);

   logic       clk;
   logic       reset;
   logic       s_tvalid;
   logic       s_tready;
   axis_data_t s_tdata;
   axis_keep_t s_tkeep;
   logic       s_tlast;
   axis_user_t s_tuser;
   logic       m_tvalid;
   logic       m_tready;
   axis_data_t m_tdata;
   axis_keep_t m_tkeep;
   logic       m_tlast;
   axis_user_t m_tuser;

   int seed;
   int sent           = 0;   // beats presented on the s side
   int recv_count     = 0;   // beats taken on the m side
   int cycle          = 0;
   int s_fire_cycle   = 0;
   int m_fire_cycle   = 0;
   bit s_fire_q       = 1'b0;   // s side transfer at the last edge
   int stall_left     = 0;
   int mismatch_count = 0;
   int other_count    = 0;

   // reference model, one queue per field
   axis_data_t exp_data[$];
   axis_keep_t exp_keep[$];
   axis_user_t exp_user[$];
   logic       exp_last[$];

   axis_pipeline_top #(
      .MODE           (MODE),
      .TREADY_RST_VAL (TREADY_RST_VAL),
      .PL_DEPTH       (PL_DEPTH)
   ) axis_pipeline_top_i (
      .clk      (clk),
      .reset    (reset),
      .s_tvalid (s_tvalid),
      .s_tready (s_tready),
      .s_tdata  (s_tdata),
      .s_tkeep  (s_tkeep),
      .s_tlast  (s_tlast),
      .s_tuser  (s_tuser),
      .m_tvalid (m_tvalid),
      .m_tready (m_tready),
      .m_tdata  (m_tdata),
      .m_tkeep  (m_tkeep),
      .m_tlast  (m_tlast),
      .m_tuser  (m_tuser)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // ---------------------------------------------------------
   // compare tasks
   // ---------------------------------------------------------

   task automatic check_data(string name, axis_data_t exp, axis_data_t act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_keep(string name, axis_keep_t exp, axis_keep_t act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_user(string name, axis_user_t exp, axis_user_t act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (act != exp) begin
         $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   // ---------------------------------------------------------
   // monitor and reference model
   // ---------------------------------------------------------

   always @(posedge clk) begin
      cycle++;
      s_fire_q = 1'b0;
      if (!reset) begin
         if (s_tvalid && s_tready) begin
            exp_data.push_back(s_tdata);
            exp_keep.push_back(s_tkeep);
            exp_user.push_back(s_tuser);
            exp_last.push_back(s_tlast);
            s_fire_q     = 1'b1;
            s_fire_cycle = cycle;
         end
         // push first, bypass moves a beat in and out on one edge
         if (m_tvalid && m_tready) begin
            m_fire_cycle = cycle;
            recv_count++;
            if (exp_data.size() == 0) begin
               $display("Error at %0t: output beat with no input beat outstanding", $time);
               other_count++;
            end else begin
               check_data("tdata", exp_data.pop_front(), m_tdata);
               check_keep("tkeep", exp_keep.pop_front(), m_tkeep);
               check_user("tuser", exp_user.pop_front(), m_tuser);
               check_bit("tlast", exp_last.pop_front(), m_tlast);
            end
         end
      end
   end

   // ---------------------------------------------------------
   // stimulus, called on the falling edge
   // ---------------------------------------------------------

   // held beat stays until taken
   task automatic step_source(int valid_pct, bit allow_new);
      if (s_tvalid && s_fire_q)
         s_tvalid = 1'b0;
      if (!s_tvalid && allow_new && rand_below(100) < valid_pct) begin
         s_tdata[63:32] = $random(seed);
         s_tdata[31:0]  = $random(seed);
         s_tkeep        = axis_keep_t'($random(seed));
         s_tuser        = axis_user_t'($random(seed));
         s_tlast        = (rand_below(8) == 0);   // one beat in eight
         s_tvalid       = 1'b1;
         sent++;
      end
   endtask

   // about 60 % ready overall once the bursts count
   task automatic step_sink();
      if (stall_left > 0) begin
         m_tready = 1'b0;
         stall_left--;
      end else if (rand_below(100) < 84) begin
         m_tready = 1'b1;
      end else begin
         m_tready   = 1'b0;
         stall_left = rand_below(6);   // burst of 1 to 6 cycles
      end
   endtask

   initial begin
      int lat_exp;
      int tput_exp;
      int start_count;
      int assert_count;

      seed     = 32'ha966642f;
      reset    = 1'b1;
      s_tvalid = 1'b0;
      s_tdata  = '0;
      s_tkeep  = '0;
      s_tlast  = 1'b0;
      s_tuser  = '0;
      m_tready = 1'b0;

      repeat (RESET_CYCLES) begin
         @(negedge clk);
         if (PASSTHRU) begin
            check_bit("m_tvalid in reset", s_tvalid, m_tvalid);
         end else begin
            check_bit("s_tready in reset", TREADY_RST_VAL, s_tready);
            check_bit("m_tvalid in reset", 1'b0, m_tvalid);
         end
      end
      reset = 1'b0;

      // random valid and ready
      while (recv_count < NUM_BEATS) begin
         step_source(70, sent < NUM_BEATS);
         step_sink();
         @(negedge clk);
      end
      step_source(0, 1'b0);

      // single beats through an empty pipeline
      lat_exp  = (MODE == MODE_BYPASS) ? 0 : PL_DEPTH;
      m_tready = 1'b1;
      repeat (3) begin
         repeat (PL_DEPTH + 2) @(negedge clk);
         step_source(100, 1'b1);
         do @(negedge clk); while (!s_fire_q);
         step_source(0, 1'b0);
         while (recv_count < sent) @(negedge clk);
         check_count("latency", lat_exp, m_fire_cycle - s_fire_cycle);
      end

      // both sides always ready, fill first
      tput_exp = (MODE == MODE_BUBBLE && PL_DEPTH > 0) ? 50 : 100;
      repeat (2 * PL_DEPTH + 4) begin
         step_source(100, 1'b1);
         @(negedge clk);
      end
      start_count = recv_count;
      repeat (100) begin
         step_source(100, 1'b1);
         @(negedge clk);
      end
      check_count("beats in 100 cycles", tput_exp, recv_count - start_count);

      // drain
      step_source(0, 1'b0);
      while (s_tvalid) begin
         @(negedge clk);
         step_source(0, 1'b0);
      end
      while (recv_count < sent) @(negedge clk);

      if (exp_data.size() != 0) begin
         $display("Error: %0d beats never came out of the pipeline", exp_data.size());
         other_count++;
      end
      assert_count = axis_pipeline_top_i.axis_pipeline_checker_i.fail_count;
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatch_count, other_count, assert_count);
      if (mismatch_count == 0 && other_count == 0 && assert_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles: %0d beats still outstanding (sent %0d, received %0d)",
               WATCHDOG_CYCLES, sent - recv_count, sent, recv_count);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* project.f */
axis_pkg.sv
axis_if.sv
axis_register.sv
axis_pipeline.sv
axis_pipeline_top.sv
axis_pipeline_checker.sv
axis_pipeline_tb.sv
